/* rtl/pcs_tx_pkg.sv */
// Transmit PCS shared definitions
package pcs_tx_pkg;

    // raw character word and coded block widths
    localparam int NB_DATA_RAW = 64;
    localparam int NB_CTRL_RAW = 8;
    localparam int NB_BLOCK    = 66;

    // sync headers, bits [1:0] of a block, bit 0 sent first
    localparam logic [1:0] SH_DATA = 2'b01;
    localparam logic [1:0] SH_CTRL = 2'b10;

    // block type field, payload byte 0 of a control block
    typedef enum logic [7:0]
    {
        BT_IDLE  = 8'h1E,
        BT_START = 8'h78,
        BT_TERM  = 8'h87
    } block_type_e;

    // error block shares the idle type, told apart by its control codes
    localparam block_type_e BT_ERROR = BT_IDLE;

    // XGMII control characters
    localparam logic [7:0] CH_IDLE  = 8'h07;
    localparam logic [7:0] CH_START = 8'hFB;
    localparam logic [7:0] CH_TERM  = 8'hFD;
    localparam logic [7:0] CH_ERROR = 8'hFE;

    // 7-bit control codes inside a control block
    localparam logic [6:0] CC_IDLE  = 7'h00;
    localparam logic [6:0] CC_ERROR = 7'h1E;

    // alignment marker payload
    // byte 0 is replaced by the lane index
    localparam logic [63:0] AM_BASE = 64'h00DE_973E_0021_68C1;

endpackage

/* rtl/pcs_encoder.sv */
// 64b/66b block encoder
module pcs_encoder
(
    input  wire                                     i_clock,
    input  wire                                     i_reset,
    input  wire                                     i_valid,
    input  wire  [pcs_tx_pkg::NB_DATA_RAW-1 : 0]    i_data,
    input  wire  [pcs_tx_pkg::NB_CTRL_RAW-1 : 0]    i_ctrl,
    input  wire                                     i_ready,

    output logic                                    o_ready,
    output logic [pcs_tx_pkg::NB_BLOCK-1 : 0]       o_block,
    output logic                                    o_valid
);

    typedef enum logic [2:0]
    {
        WC_DATA,
        WC_IDLE,
        WC_START,
        WC_TERM,
        WC_ERROR
    } word_class_e;

    word_class_e                                word_class;
    logic [pcs_tx_pkg::NB_CTRL_RAW-1 : 0]       idle_match;
    logic [pcs_tx_pkg::NB_BLOCK-1 : 0]          coded;
    logic                                       run;

    // one flag per byte lane carrying an idle character
    always_comb
    begin
        for (int b = 0; b < pcs_tx_pkg::NB_CTRL_RAW; b++)
        begin
            idle_match[b] = (i_data[8*b +: 8] == pcs_tx_pkg::CH_IDLE);
        end
    end

    // only lane 0 start and terminate are supported
    always_comb
    begin
        if (i_ctrl == '0)
            word_class = WC_DATA;
        else if (i_ctrl == '1 && &idle_match)
            word_class = WC_IDLE;
        else if (i_ctrl == 8'h01 && i_data[7:0] == pcs_tx_pkg::CH_START)
            word_class = WC_START;
        else if (i_ctrl == '1 && i_data[7:0] == pcs_tx_pkg::CH_TERM && &idle_match[7:1])
            word_class = WC_TERM;
        else
            word_class = WC_ERROR;
    end

    always_comb
    begin
        case (word_class)
            WC_DATA:
                coded = {i_data, pcs_tx_pkg::SH_DATA};
            WC_IDLE:
                coded = {{8{pcs_tx_pkg::CC_IDLE}}, pcs_tx_pkg::BT_IDLE, pcs_tx_pkg::SH_CTRL};
            WC_START:
                coded = {i_data[63:8], pcs_tx_pkg::BT_START, pcs_tx_pkg::SH_CTRL};
            // seven reserved bits follow the type field
            WC_TERM:
                coded = {{7{pcs_tx_pkg::CC_IDLE}}, 7'b0, pcs_tx_pkg::BT_TERM,
                         pcs_tx_pkg::SH_CTRL};
            default:
                coded = {{8{pcs_tx_pkg::CC_ERROR}}, pcs_tx_pkg::BT_ERROR, pcs_tx_pkg::SH_CTRL};
        endcase
    end

    // accept when the register is empty or drains this cycle
    assign o_ready = run && (!o_valid || i_ready);

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            run     <= 1'b0;
            o_valid <= 1'b0;
        end
        else
        begin
            run <= 1'b1;
            if (o_ready)
                o_valid <= i_valid;
        end
    end

    // block held while the slotter stalls
    always_ff @(posedge i_clock)
    begin
        if (o_ready && i_valid)
            o_block <= coded;
    end

endmodule

/* rtl/pcs_marker_slotter.sv */
// Alignment marker slot insertion
module pcs_marker_slotter
#(
    parameter int   N_LANES     = 4,
    parameter int   AM_PERIOD   = 4
)
(
    input  wire                                     i_clock,
    input  wire                                     i_reset,
    input  wire  [pcs_tx_pkg::NB_BLOCK-1 : 0]       i_block,
    input  wire                                     i_valid,

    output logic                                    o_ready,
    output logic [pcs_tx_pkg::NB_BLOCK-1 : 0]       o_block,
    output logic                                    o_tag,
    output logic                                    o_valid
);

    localparam int DATA_BLOCKS = AM_PERIOD * N_LANES;
    localparam int CNT_W       = $clog2(DATA_BLOCKS + 1);

    typedef enum logic
    {
        ST_MARKER,
        ST_DATA
    } slot_state_e;

    slot_state_e            state;
    logic [CNT_W-1 : 0]     count;
    logic                   take;
    logic                   step;
    logic                   last;

    // input is only drained in the data phase
    assign o_ready = (state == ST_DATA);
    assign take    = o_ready && i_valid;

    // every marker cycle emits a slot, data cycles need a block
    assign step = (state == ST_MARKER) || take;

    always_comb
    begin
        if (state == ST_MARKER)
            last = (count == CNT_W'(N_LANES - 1));
        else
            last = (count == CNT_W'(DATA_BLOCKS - 1));
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state   <= ST_MARKER;
            count   <= '0;
            o_valid <= 1'b0;
            o_tag   <= 1'b0;
        end
        else
        begin
            o_valid <= step;
            o_tag   <= (state == ST_MARKER);
            if (step)
            begin
                if (last)
                begin
                    count <= '0;
                    state <= (state == ST_MARKER) ? ST_DATA : ST_MARKER;
                end
                else
                    count <= count + 1'b1;
            end
        end
    end

    // empty slot, the distributor fills in the marker
    always_ff @(posedge i_clock)
    begin
        if (step)
            o_block <= (state == ST_MARKER) ? '0 : i_block;
    end

endmodule

/* rtl/pcs_scrambler.sv */
// Self-synchronous payload scrambler
module pcs_scrambler
#(
    parameter logic [57:0]  SEED    = {58{1'b1}}
)
(
    input  wire                                     i_clock,
    input  wire                                     i_reset,
    input  wire  [pcs_tx_pkg::NB_BLOCK-1 : 0]       i_block,
    input  wire                                     i_tag,
    input  wire                                     i_valid,
    input  wire                                     i_bypass,

    output logic [pcs_tx_pkg::NB_BLOCK-1 : 0]       o_block,
    output logic                                    o_tag,
    output logic                                    o_valid
);

    localparam int NB_SCR     = 58;
    localparam int NB_PAYLOAD = pcs_tx_pkg::NB_BLOCK - 2;

    // 1 + x^39 + x^58
    localparam int TAP_A = 38;
    localparam int TAP_B = 57;

    logic [NB_SCR-1 : 0]        state;
    logic [NB_SCR-1 : 0]        state_next;
    logic [NB_PAYLOAD-1 : 0]    payload_in;
    logic [NB_PAYLOAD-1 : 0]    scr_payload;
    logic                       pass;

    assign payload_in = i_block[pcs_tx_pkg::NB_BLOCK-1 : 2];

    // markers and bypass leave the block untouched
    assign pass = i_tag || i_bypass;

    // bit 0 first, each scrambled bit feeds back into the state
    always_comb
    begin
        state_next = state;
        for (int i = 0; i < NB_PAYLOAD; i++)
        begin
            scr_payload[i] = payload_in[i] ^ state_next[TAP_A] ^ state_next[TAP_B];
            state_next     = {state_next[NB_SCR-2 : 0], scr_payload[i]};
        end
    end

    // state still runs in bypass so it stays aligned with the stream
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            state <= SEED;
        else if (i_valid && !i_tag)
            state <= state_next;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_valid <= 1'b0;
            o_tag   <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid;
            o_tag   <= i_valid && i_tag;
        end
    end

    // sync header always passes in the clear
    always_ff @(posedge i_clock)
    begin
        if (i_valid)
            o_block <= pass ? i_block : {scr_payload, i_block[1:0]};
    end

endmodule

/* rtl/pcs_lane_distributor.sv */
// Round-robin lane distributor with marker fill
module pcs_lane_distributor
#(
    parameter int   N_LANES     = 4
)
(
    input  wire                                             i_clock,
    input  wire                                             i_reset,
    input  wire  [pcs_tx_pkg::NB_BLOCK-1 : 0]               i_block,
    input  wire                                             i_tag,
    input  wire                                             i_valid,

    output logic [(pcs_tx_pkg::NB_BLOCK*N_LANES)-1 : 0]     o_row,
    output logic                                            o_row_valid,
    output logic                                            o_row_is_marker
);

    localparam int LANE_W = (N_LANES > 1) ? $clog2(N_LANES) : 1;

    logic [LANE_W-1 : 0]                    lane;
    logic                                   last_lane;
    logic [pcs_tx_pkg::NB_BLOCK-1 : 0]      marker;
    logic [pcs_tx_pkg::NB_BLOCK-1 : 0]      lane_block;
    logic                                   tag_acc;
    logic                                   row_tag;

    assign last_lane = (lane == LANE_W'(N_LANES - 1));

    // lane index goes into marker byte 0
    assign marker = {pcs_tx_pkg::AM_BASE[63:8], 8'(lane), pcs_tx_pkg::SH_CTRL};

    assign lane_block = i_tag ? marker : i_block;

    // true while every slot of the row so far was tagged
    assign row_tag = i_tag && ((lane == '0) || tag_acc);

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            lane            <= '0;
            tag_acc         <= 1'b0;
            o_row_valid     <= 1'b0;
            o_row_is_marker <= 1'b0;
        end
        else
        begin
            o_row_valid <= i_valid && last_lane;
            if (i_valid)
            begin
                lane    <= last_lane ? '0 : lane + 1'b1;
                tag_acc <= row_tag;
                if (last_lane)
                    o_row_is_marker <= row_tag;
            end
        end
    end

    // lane 0 in the low bits
    always_ff @(posedge i_clock)
    begin
        if (i_valid)
            o_row[lane*pcs_tx_pkg::NB_BLOCK +: pcs_tx_pkg::NB_BLOCK] <= lane_block;
    end

endmodule

/* rtl/pcs_tx_top.sv */
// Multi-lane 64b/66b transmit PCS
module pcs_tx_top
#(
    parameter int           N_LANES     = 4,
    parameter int           AM_PERIOD   = 4,
    parameter logic [57:0]  SEED        = {58{1'b1}}
)
(
    input  wire                                             i_clock,
    input  wire                                             i_reset,
    input  wire                                             i_valid,
    input  wire  [pcs_tx_pkg::NB_DATA_RAW-1 : 0]            i_data,
    input  wire  [pcs_tx_pkg::NB_CTRL_RAW-1 : 0]            i_ctrl,
    input  wire                                             i_bypass,

    output wire                                             o_ready,
    output wire  [(pcs_tx_pkg::NB_BLOCK*N_LANES)-1 : 0]     o_row,
    output wire                                             o_row_valid,
    output wire                                             o_row_is_marker
);

    // encoder to slotter
    wire [pcs_tx_pkg::NB_BLOCK-1 : 0]   enc_block;
    wire                                enc_valid;
    wire                                slot_ready;

    // slotter to scrambler
    wire [pcs_tx_pkg::NB_BLOCK-1 : 0]   slot_block;
    wire                                slot_tag;
    wire                                slot_valid;

    // scrambler to distributor
    wire [pcs_tx_pkg::NB_BLOCK-1 : 0]   scr_block;
    wire                                scr_tag;
    wire                                scr_valid;

    pcs_encoder
    u_encoder
    (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_valid    (i_valid),
        .i_data     (i_data),
        .i_ctrl     (i_ctrl),
        .i_ready    (slot_ready),
        .o_ready    (o_ready),
        .o_block    (enc_block),
        .o_valid    (enc_valid)
    );

    pcs_marker_slotter
    #(
        .N_LANES    (N_LANES),
        .AM_PERIOD  (AM_PERIOD)
    )
    u_slotter
    (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_block    (enc_block),
        .i_valid    (enc_valid),
        .o_ready    (slot_ready),
        .o_block    (slot_block),
        .o_tag      (slot_tag),
        .o_valid    (slot_valid)
    );

    pcs_scrambler
    #(
        .SEED       (SEED)
    )
    u_scrambler
    (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_block    (slot_block),
        .i_tag      (slot_tag),
        .i_valid    (slot_valid),
        .i_bypass   (i_bypass),
        .o_block    (scr_block),
        .o_tag      (scr_tag),
        .o_valid    (scr_valid)
    );

    pcs_lane_distributor
    #(
        .N_LANES    (N_LANES)
    )
    u_distributor
    (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_block            (scr_block),
        .i_tag              (scr_tag),
        .i_valid            (scr_valid),
        .o_row              (o_row),
        .o_row_valid        (o_row_valid),
        .o_row_is_marker    (o_row_is_marker)
    );

endmodule

/* verification/pcs_tx_tb.sv */
// Transmit PCS testbench
module pcs_tx_tb;

    localparam int          N_LANES        = 4;
    localparam int          AM_PERIOD      = 4;
    localparam logic [57:0] SEED           = {58{1'b1}};
    localparam int          NB_BLOCK       = pcs_tx_pkg::NB_BLOCK;
    localparam int          CLK_PERIOD     = 100;
    localparam int          RESET_CYCLES   = 8;
    localparam int          N_ROWS         = 40;
    localparam int          BYPASS_WORDS   = 4 * AM_PERIOD * N_LANES;
    localparam int          ACCEPT_TIMEOUT = 2000;
    localparam int          DRAIN_TIMEOUT  = 200;
    localparam int          ROW_TIMEOUT    = 4000;

    logic                           i_clock = 1'b0;
    logic                           i_reset;
    logic                           i_valid;
    logic [63:0]                    i_data;
    logic [7:0]                     i_ctrl;
    logic                           i_bypass;
    wire                            o_ready;
    wire  [NB_BLOCK*N_LANES-1 : 0]  o_row;
    wire                            o_row_valid;
    wire                            o_row_is_marker;

    integer         seed         = 32'h3392;
    logic [57:0]    model_state  = SEED;
    logic [65:0]    expected[$];
    logic           took_word    = 1'b0;
    int             accepted     = 0;
    int             rows_checked = 0;

    pcs_tx_top
    #(
        .N_LANES    (N_LANES),
        .AM_PERIOD  (AM_PERIOD),
        .SEED       (SEED)
    )
    i_dut
    (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_valid            (i_valid),
        .i_data             (i_data),
        .i_ctrl             (i_ctrl),
        .i_bypass           (i_bypass),
        .o_ready            (o_ready),
        .o_row              (o_row),
        .o_row_valid        (o_row_valid),
        .o_row_is_marker    (o_row_is_marker)
    );

    always #(CLK_PERIOD / 2) i_clock = ~i_clock;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic report_mismatch(input string what, input logic [65:0] want,
                                   input logic [65:0] got);
        $display("[ERROR] %s expected %h got %h", what, want, got);
        abort_run("output value mismatch");
    endtask

    // 64b/66b coding of one character word, lane 0 start and terminate only
    function automatic logic [65:0] encode_word(input logic [63:0] data, input logic [7:0] ctrl);
        logic all_idle;
        logic upper_idle;
        all_idle   = 1'b1;
        upper_idle = 1'b1;
        for (int b = 0; b < 8; b++)
        begin
            if (data[8*b +: 8] != pcs_tx_pkg::CH_IDLE)
            begin
                all_idle = 1'b0;
                if (b > 0)
                    upper_idle = 1'b0;
            end
        end
        if (ctrl == 8'h00)
            return {data, pcs_tx_pkg::SH_DATA};
        if (ctrl == 8'hFF && all_idle)
            return {{8{pcs_tx_pkg::CC_IDLE}}, pcs_tx_pkg::BT_IDLE, pcs_tx_pkg::SH_CTRL};
        if (ctrl == 8'h01 && data[7:0] == pcs_tx_pkg::CH_START)
            return {data[63:8], pcs_tx_pkg::BT_START, pcs_tx_pkg::SH_CTRL};
        if (ctrl == 8'hFF && data[7:0] == pcs_tx_pkg::CH_TERM && upper_idle)
            return {{7{pcs_tx_pkg::CC_IDLE}}, 7'h00, pcs_tx_pkg::BT_TERM, pcs_tx_pkg::SH_CTRL};
        return {{8{pcs_tx_pkg::CC_ERROR}}, pcs_tx_pkg::BT_ERROR, pcs_tx_pkg::SH_CTRL};
    endfunction

    // 1 + x^39 + x^58, lsb first, output bit fed back
    function automatic logic [63:0] scramble_payload(input logic [63:0] din);
        logic [63:0] dout;
        for (int i = 0; i < 64; i++)
        begin
            dout[i]     = din[i] ^ model_state[38] ^ model_state[57];
            model_state = {model_state[56:0], dout[i]};
        end
        return dout;
    endfunction

    task automatic push_expected(input logic [63:0] data, input logic [7:0] ctrl);
        logic [65:0] coded;
        logic [63:0] scrambled;
        coded     = encode_word(data, ctrl);
        // model state runs in bypass too
        scrambled = scramble_payload(coded[65:2]);
        if (i_bypass)
            expected.push_back(coded);
        else
            expected.push_back({scrambled, coded[1:0]});
        accepted++;
    endtask

    task automatic pick_word();
        int kind;
        kind    = int'({$random(seed)} % 5);
        i_valid = ($random(seed) & 3) != 0;
        i_data  = {$random(seed), $random(seed)};
        if (kind == 0)
            i_ctrl = 8'h00;
        else if (kind == 1)
        begin
            i_ctrl = 8'hFF;
            i_data = {8{pcs_tx_pkg::CH_IDLE}};
        end
        else if (kind == 2)
        begin
            i_ctrl      = 8'h01;
            i_data[7:0] = pcs_tx_pkg::CH_START;
        end
        else if (kind == 3)
        begin
            i_ctrl = 8'hFF;
            i_data = {{7{pcs_tx_pkg::CH_IDLE}}, pcs_tx_pkg::CH_TERM};
        end
        else
            i_ctrl = 8'($random(seed));
    endtask

    // o_ready is stable here until the next rising edge
    task automatic drive_cycle();
        if (!i_valid || took_word)
            pick_word();
        took_word = i_valid && o_ready;
        if (took_word)
            push_expected(i_data, i_ctrl);
    endtask

    task automatic check_row();
        logic [65:0] want;
        logic [65:0] got;
        logic        marker_row;
        marker_row = (rows_checked % (AM_PERIOD + 1)) == 0;
        assert (o_row_is_marker == marker_row)
        else report_mismatch($sformatf("o_row_is_marker row %0d", rows_checked),
                             66'(marker_row), 66'(o_row_is_marker));
        if (!marker_row)
            assert (expected.size() >= N_LANES)
            else abort_run($sformatf("row %0d arrived without enough accepted words",
                                     rows_checked));
        for (int k = 0; k < N_LANES; k++)
        begin
            if (marker_row)
                want = {pcs_tx_pkg::AM_BASE[63:8], 8'(k), pcs_tx_pkg::SH_CTRL};
            else
                want = expected.pop_front();
            got = o_row[k*NB_BLOCK +: NB_BLOCK];
            assert (got == want)
            else report_mismatch($sformatf("o_row row %0d lane %0d", rows_checked, k),
                                 want, got);
        end
        rows_checked++;
    endtask

    always @(posedge i_clock)
    begin
        if (!i_reset && o_row_valid)
            check_row();
    end

    initial
    begin : driver
        int waited;
        i_reset  = 1'b1;
        i_valid  = 1'b0;
        i_data   = '0;
        i_ctrl   = '0;
        i_bypass = 1'b1;
        repeat (RESET_CYCLES) @(negedge i_clock);
        assert (!o_ready) else report_mismatch("o_ready in reset", '0, 66'(o_ready));
        assert (!o_row_valid) else report_mismatch("o_row_valid in reset", '0, 66'(o_row_valid));
        i_reset = 1'b0;
        waited  = 0;
        // first pass with the scrambler bypassed
        while (accepted < BYPASS_WORDS && waited < ACCEPT_TIMEOUT)
        begin
            @(negedge i_clock);
            drive_cycle();
            waited++;
        end
        if (accepted < BYPASS_WORDS)
            abort_run("timeout waiting for the DUT to accept input words");
        else
        begin
            @(negedge i_clock);
            i_valid   = 1'b0;
            took_word = 1'b0;
            waited    = 0;
            // every accepted word out before bypass drops
            while (expected.size() != 0 && waited < DRAIN_TIMEOUT)
            begin
                @(negedge i_clock);
                waited++;
            end
            if (expected.size() != 0)
                abort_run("timeout waiting for the pipeline to drain");
            else
            begin
                i_bypass = 1'b0;
                forever
                begin
                    @(negedge i_clock);
                    drive_cycle();
                end
            end
        end
    end

    initial
    begin : run_control
        int waited;
        waited = 0;
        while (rows_checked < N_ROWS && waited < ROW_TIMEOUT)
        begin
            @(negedge i_clock);
            waited++;
        end
        if (rows_checked >= N_ROWS)
        begin
            $display("SIMULATION PASSED");
            $finish;
        end
        else
            abort_run("timeout waiting for output rows");
    end

endmodule

/* pcs_tx.f */
rtl/pcs_tx_pkg.sv
rtl/pcs_encoder.sv
rtl/pcs_marker_slotter.sv
rtl/pcs_scrambler.sv
rtl/pcs_lane_distributor.sv
rtl/pcs_tx_top.sv
verification/pcs_tx_tb.sv

/* Makefile */
# simulator, flags, top module and file list
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := pcs_tx_tb
FILELIST  := pcs_tx.f
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
